//--- Makefile
VERILATOR  = verilator
FILELIST   = filelist.f
TOP        = decode_stage_tb
RTL_TOP    = decode_stage
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ns
SIM_FLAGS  = --binary --timing --timescale 1ns/1ns -j 0
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/instr_decoder.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/load_use_detect.sv
logic/id_ex_reg.sv
logic/decode_stage.sv
tests/decode_stage_tb.sv

//--- logic/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  rv_decode_pkg::xlen_t     pc_i,
    input  rv_decode_pkg::instr_t    instr_i,
    input  rv_decode_pkg::xlen_t     wb_data_i,
    input  rv_decode_pkg::reg_idx_t  wb_rd_i,
    input  logic                     wb_wren_i,
    output logic                     stall_o,
    output rv_decode_pkg::xlen_t     pc_ex_o,
    output rv_decode_pkg::xlen_t     rs1_data_ex_o,
    output rv_decode_pkg::xlen_t     rs2_data_ex_o,
    output rv_decode_pkg::xlen_t     imm_ex_o,
    output logic                     src1_sel_ex_o,
    output rv_decode_pkg::src2_sel_t src2_sel_ex_o,
    output rv_decode_pkg::alu_ctrl_t alu_ctrl_ex_o,
    output rv_decode_pkg::reg_idx_t  rd_ex_o,
    output logic                     is_jal_ex_o,
    output logic                     is_jalr_ex_o,
    output logic                     is_brc_ex_o,
    output logic                     is_load_ex_o,
    output logic                     is_store_ex_o,
    output logic                     wben_ex_o
);

    import rv_decode_pkg::*;

    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    reg_idx_t  rd_idx;
    ext_op_t   ext_op;
    logic      src1_sel;
    src2_sel_t src2_sel;
    alu_ctrl_t alu_ctrl;
    logic      is_jal;
    logic      is_jalr;
    logic      is_brc;
    logic      is_load;
    logic      is_store;
    logic      wben;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;

    instr_decoder u_decoder (
        .instr_i    (instr_i),
        .rs1_idx_o  (rs1_idx),
        .rs2_idx_o  (rs2_idx),
        .rd_idx_o   (rd_idx),
        .ext_op_o   (ext_op),
        .src1_sel_o (src1_sel),
        .src2_sel_o (src2_sel),
        .alu_ctrl_o (alu_ctrl),
        .is_jal_o   (is_jal),
        .is_jalr_o  (is_jalr),
        .is_brc_o   (is_brc),
        .is_load_o  (is_load),
        .is_store_o (is_store),
        .wben_o     (wben)
    );

    imm_gen u_imm_gen (
        .instr_imm_i (instr_i[31:7]),
        .ext_op_i    (ext_op),
        .imm_o       (imm)
    );

    // written by the writeback stage
    reg_file u_reg_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_idx),
        .rs2_addr_i (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_addr_i  (wb_rd_i),
        .wr_data_i  (wb_data_i),
        .wr_en_i    (wb_wren_i)
    );

    // compares against the instruction already sitting in EX
    load_use_detect u_hazard (
        .rs1_idx_i    (rs1_idx),
        .rs2_idx_i    (rs2_idx),
        .is_load_ex_i (is_load_ex_o),
        .rd_ex_i      (rd_ex_o),
        .stall_o      (stall_o)
    );

    id_ex_reg u_id_ex (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall_o),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .imm_i         (imm),
        .src1_sel_i    (src1_sel),
        .src2_sel_i    (src2_sel),
        .alu_ctrl_i    (alu_ctrl),
        .rd_i          (rd_idx),
        .is_jal_i      (is_jal),
        .is_jalr_i     (is_jalr),
        .is_brc_i      (is_brc),
        .is_load_i     (is_load),
        .is_store_i    (is_store),
        .wben_i        (wben),
        .pc_ex_o       (pc_ex_o),
        .rs1_data_ex_o (rs1_data_ex_o),
        .rs2_data_ex_o (rs2_data_ex_o),
        .imm_ex_o      (imm_ex_o),
        .src1_sel_ex_o (src1_sel_ex_o),
        .src2_sel_ex_o (src2_sel_ex_o),
        .alu_ctrl_ex_o (alu_ctrl_ex_o),
        .rd_ex_o       (rd_ex_o),
        .is_jal_ex_o   (is_jal_ex_o),
        .is_jalr_ex_o  (is_jalr_ex_o),
        .is_brc_ex_o   (is_brc_ex_o),
        .is_load_ex_o  (is_load_ex_o),
        .is_store_ex_o (is_store_ex_o),
        .wben_ex_o     (wben_ex_o)
    );

endmodule

//--- logic/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     stall_i,
    input  rv_decode_pkg::xlen_t     pc_i,
    input  rv_decode_pkg::xlen_t     rs1_data_i,
    input  rv_decode_pkg::xlen_t     rs2_data_i,
    input  rv_decode_pkg::xlen_t     imm_i,
    input  logic                     src1_sel_i,
    input  rv_decode_pkg::src2_sel_t src2_sel_i,
    input  rv_decode_pkg::alu_ctrl_t alu_ctrl_i,
    input  rv_decode_pkg::reg_idx_t  rd_i,
    input  logic                     is_jal_i,
    input  logic                     is_jalr_i,
    input  logic                     is_brc_i,
    input  logic                     is_load_i,
    input  logic                     is_store_i,
    input  logic                     wben_i,
    output rv_decode_pkg::xlen_t     pc_ex_o,
    output rv_decode_pkg::xlen_t     rs1_data_ex_o,
    output rv_decode_pkg::xlen_t     rs2_data_ex_o,
    output rv_decode_pkg::xlen_t     imm_ex_o,
    output logic                     src1_sel_ex_o,
    output rv_decode_pkg::src2_sel_t src2_sel_ex_o,
    output rv_decode_pkg::alu_ctrl_t alu_ctrl_ex_o,
    output rv_decode_pkg::reg_idx_t  rd_ex_o,
    output logic                     is_jal_ex_o,
    output logic                     is_jalr_ex_o,
    output logic                     is_brc_ex_o,
    output logic                     is_load_ex_o,
    output logic                     is_store_ex_o,
    output logic                     wben_ex_o
);

    // operands and selects, meaningless inside a bubble
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_ex_o       <= '0;
            rs1_data_ex_o <= '0;
            rs2_data_ex_o <= '0;
            imm_ex_o      <= '0;
            src1_sel_ex_o <= 1'b0;
            src2_sel_ex_o <= '0;
            alu_ctrl_ex_o <= '0;
        end else begin
            pc_ex_o       <= pc_i;
            rs1_data_ex_o <= rs1_data_i;
            rs2_data_ex_o <= rs2_data_i;
            imm_ex_o      <= imm_i;
            src1_sel_ex_o <= src1_sel_i;
            src2_sel_ex_o <= src2_sel_i;
            alu_ctrl_ex_o <= alu_ctrl_i;
        end
    end

    // control side, stall turns the slot into a bubble
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ex_o       <= '0;
            is_jal_ex_o   <= 1'b0;
            is_jalr_ex_o  <= 1'b0;
            is_brc_ex_o   <= 1'b0;
            is_load_ex_o  <= 1'b0;
            is_store_ex_o <= 1'b0;
            wben_ex_o     <= 1'b0;
        end else if (stall_i) begin
            rd_ex_o       <= '0;
            is_jal_ex_o   <= 1'b0;
            is_jalr_ex_o  <= 1'b0;
            is_brc_ex_o   <= 1'b0;
            is_load_ex_o  <= 1'b0;
            is_store_ex_o <= 1'b0;
            wben_ex_o     <= 1'b0;
        end else begin
            rd_ex_o       <= rd_i;
            is_jal_ex_o   <= is_jal_i;
            is_jalr_ex_o  <= is_jalr_i;
            is_brc_ex_o   <= is_brc_i;
            is_load_ex_o  <= is_load_i;
            is_store_ex_o <= is_store_i;
            wben_ex_o     <= wben_i;
        end
    end

endmodule

//--- logic/imm_gen.sv
`timescale 1ns/1ns
`include "rv_decode_params.svh"

module imm_gen (
    input  logic [31:7]            instr_imm_i,
    input  rv_decode_pkg::ext_op_t ext_op_i,
    output rv_decode_pkg::xlen_t   imm_o
);

    logic sign;

    // every format takes its sign from instruction bit 31
    assign sign = instr_imm_i[31];

    always_comb begin
        case (ext_op_i)
            `IMM_I: imm_o = {{(`XLEN-12){sign}}, instr_imm_i[31:20]};
            `IMM_S: imm_o = {{(`XLEN-12){sign}}, instr_imm_i[31:25], instr_imm_i[11:7]};
            `IMM_U: imm_o = {{(`XLEN-32){sign}}, instr_imm_i[31:12], 12'h000};
            // branch offset, bit 0 always zero
            `IMM_B: imm_o = {{(`XLEN-12){sign}}, instr_imm_i[7], instr_imm_i[30:25],
                             instr_imm_i[11:8], 1'b0};
            // jump offset, bit 0 always zero
            `IMM_J: imm_o = {{(`XLEN-20){sign}}, instr_imm_i[19:12], instr_imm_i[20],
                             instr_imm_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/1ns
`include "rv_decode_params.svh"

module instr_decoder (
    input  rv_decode_pkg::instr_t    instr_i,
    output rv_decode_pkg::reg_idx_t  rs1_idx_o,
    output rv_decode_pkg::reg_idx_t  rs2_idx_o,
    output rv_decode_pkg::reg_idx_t  rd_idx_o,
    output rv_decode_pkg::ext_op_t   ext_op_o,
    output logic                     src1_sel_o,
    output rv_decode_pkg::src2_sel_t src2_sel_o,
    output rv_decode_pkg::alu_ctrl_t alu_ctrl_o,
    output logic                     is_jal_o,
    output logic                     is_jalr_o,
    output logic                     is_brc_o,
    output logic                     is_load_o,
    output logic                     is_store_o,
    output logic                     wben_o
);

    import rv_decode_pkg::*;

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       word_op;
    logic       writes_rd;
    reg_idx_t   rs1_fld;
    reg_idx_t   rs2_fld;
    reg_idx_t   rd_fld;

    assign opcode  = instr_i[6:2];
    assign funct3  = instr_i[14:12];
    assign alt     = instr_i[30];
    // opcode bit 3 marks the W forms
    assign word_op = instr_i[3];
    assign rs1_fld = instr_i[19:15];
    assign rs2_fld = instr_i[24:20];
    assign rd_fld  = instr_i[11:7];

    // shared by register and immediate forms
    // sub only exists in the register form, bit 30 is part of the immediate otherwise
    function automatic alu_ctrl_t funct_to_alu(input logic [2:0] f3, input logic alt_bit,
                                               input logic word, input logic reg_form);
        alu_ctrl_t ctrl;
        ctrl = `ALU_ADD_64;
        case (f3)
            `F3_ADD_SUB: begin
                if (alt_bit && reg_form) begin
                    ctrl = word ? `ALU_SUB_32 : `ALU_SUB_64;
                end else begin
                    ctrl = word ? `ALU_ADD_32 : `ALU_ADD_64;
                end
            end
            `F3_SLL:  ctrl = word ? `ALU_SLL_32 : `ALU_SLL_64;
            `F3_SLT:  ctrl = `ALU_SLT;
            `F3_SLTU: ctrl = `ALU_SLTU;
            `F3_XOR:  ctrl = `ALU_XOR;
            `F3_SRL_SRA: begin
                if (alt_bit) begin
                    ctrl = word ? `ALU_SRA_32 : `ALU_SRA_64;
                end else begin
                    ctrl = word ? `ALU_SRL_32 : `ALU_SRL_64;
                end
            end
            `F3_OR:   ctrl = `ALU_OR;
            default:  ctrl = `ALU_AND;
        endcase
        return ctrl;
    endfunction

    always_comb begin
        rs1_idx_o  = '0;
        rs2_idx_o  = '0;
        ext_op_o   = '0;
        src1_sel_o = `SRC1_RS1;
        src2_sel_o = `SRC2_RS2;
        alu_ctrl_o = `ALU_ADD_64;
        is_jal_o   = 1'b0;
        is_jalr_o  = 1'b0;
        is_brc_o   = 1'b0;
        is_load_o  = 1'b0;
        is_store_o = 1'b0;
        writes_rd  = 1'b0;
        case (opcode)
            `OP_REG, `OP_REG_32: begin
                rs1_idx_o  = rs1_fld;
                rs2_idx_o  = rs2_fld;
                alu_ctrl_o = funct_to_alu(funct3, alt, word_op, 1'b1);
                writes_rd  = 1'b1;
            end
            `OP_IMM, `OP_IMM_32: begin
                rs1_idx_o  = rs1_fld;
                ext_op_o   = `IMM_I;
                src2_sel_o = `SRC2_IMM;
                alu_ctrl_o = funct_to_alu(funct3, alt, word_op, 1'b0);
                writes_rd  = 1'b1;
            end
            `LOAD: begin
                rs1_idx_o  = rs1_fld;
                ext_op_o   = `IMM_I;
                src2_sel_o = `SRC2_IMM;
                is_load_o  = 1'b1;
                writes_rd  = 1'b1;
            end
            `STORE: begin
                rs1_idx_o  = rs1_fld;
                rs2_idx_o  = rs2_fld;
                ext_op_o   = `IMM_S;
                src2_sel_o = `SRC2_IMM;
                is_store_o = 1'b1;
            end
            `BRANCH: begin
                rs1_idx_o = rs1_fld;
                rs2_idx_o = rs2_fld;
                ext_op_o  = `IMM_B;
                is_brc_o  = 1'b1;
            end
            // link value is pc + 4, target is resolved further down
            `JAL: begin
                ext_op_o   = `IMM_J;
                src1_sel_o = `SRC1_PC;
                src2_sel_o = `SRC2_FOUR;
                is_jal_o   = 1'b1;
                writes_rd  = 1'b1;
            end
            `JALR: begin
                rs1_idx_o  = rs1_fld;
                ext_op_o   = `IMM_I;
                src1_sel_o = `SRC1_PC;
                src2_sel_o = `SRC2_FOUR;
                is_jalr_o  = 1'b1;
                writes_rd  = 1'b1;
            end
            `LUI: begin
                ext_op_o   = `IMM_U;
                src2_sel_o = `SRC2_IMM;
                alu_ctrl_o = `ALU_SRC2;
                writes_rd  = 1'b1;
            end
            `AUIPC: begin
                ext_op_o   = `IMM_U;
                src1_sel_o = `SRC1_PC;
                src2_sel_o = `SRC2_IMM;
                writes_rd  = 1'b1;
            end
            // csr, system and unknown opcodes fall through as a no-op
            default: begin
                writes_rd = 1'b0;
            end
        endcase
        rd_idx_o = writes_rd ? rd_fld : '0;
        wben_o   = writes_rd && (rd_fld != '0);
    end

endmodule

//--- logic/load_use_detect.sv
`timescale 1ns/1ns

module load_use_detect (
    input  rv_decode_pkg::reg_idx_t rs1_idx_i,
    input  rv_decode_pkg::reg_idx_t rs2_idx_i,
    input  logic                    is_load_ex_i,
    input  rv_decode_pkg::reg_idx_t rd_ex_i,
    output logic                    stall_o
);

    logic rs1_hit;
    logic rs2_hit;
    logic load_pending;

    // a load into x0 never produces a value worth waiting for
    assign load_pending = is_load_ex_i && (rd_ex_i != '0);

    // unused sources come in as x0 from the decoder
    assign rs1_hit = (rs1_idx_i == rd_ex_i);
    assign rs2_hit = (rs2_idx_i == rd_ex_i);

    assign stall_o = load_pending && (rs1_hit || rs2_hit);

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  rv_decode_pkg::reg_idx_t rs1_addr_i,
    input  rv_decode_pkg::reg_idx_t rs2_addr_i,
    output rv_decode_pkg::xlen_t    rs1_data_o,
    output rv_decode_pkg::xlen_t    rs2_data_o,
    input  rv_decode_pkg::reg_idx_t wr_addr_i,
    input  rv_decode_pkg::xlen_t    wr_data_i,
    input  logic                    wr_en_i
);

    import rv_decode_pkg::*;

    xlen_t regs [32];

    // writeback port skips x0 so it keeps its reset value of zero
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // no bypass so a write shows up only after the edge
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

//--- logic/rv_decode_params.svh
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

`define XLEN        64
`define INST_LEN    32

// opcode[6:2]
`define OP_REG      5'b01100
`define OP_REG_32   5'b01110
`define OP_IMM      5'b00100
`define OP_IMM_32   5'b00110
`define LOAD        5'b00000
`define STORE       5'b01000
`define BRANCH      5'b11000
`define JAL         5'b11011
`define JALR        5'b11001
`define LUI         5'b01101
`define AUIPC       5'b00101

// funct3 of the integer ALU ops
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// alu control, 5 bits
`define ALU_ADD_64  5'd0
`define ALU_ADD_32  5'd1
`define ALU_SUB_64  5'd2
`define ALU_SUB_32  5'd3
`define ALU_SLL_64  5'd4
`define ALU_SLL_32  5'd5
`define ALU_SRL_64  5'd6
`define ALU_SRL_32  5'd7
`define ALU_SRA_64  5'd8
`define ALU_SRA_32  5'd9
`define ALU_SLT     5'd10
`define ALU_SLTU    5'd11
`define ALU_XOR     5'd12
`define ALU_OR      5'd13
`define ALU_AND     5'd14
`define ALU_SRC2    5'd15

// operand selects
`define SRC1_RS1    1'b0
`define SRC1_PC     1'b1
`define SRC2_RS2    2'b00
`define SRC2_IMM    2'b01
`define SRC2_FOUR   2'b10

// immediate formats, one-hot
`define IMM_I       5'b00001
`define IMM_U       5'b00010
`define IMM_S       5'b00100
`define IMM_J       5'b01000
`define IMM_B       5'b10000

`endif

//--- logic/rv_decode_pkg.sv
`include "rv_decode_params.svh"

package rv_decode_pkg;

    // one data word, register file and pc width
    typedef logic [`XLEN-1:0] xlen_t;

    // raw fetched instruction
    typedef logic [`INST_LEN-1:0] instr_t;

    // architectural register index, x0..x31
    typedef logic [4:0] reg_idx_t;

    // alu operation code carried into EX
    typedef logic [4:0] alu_ctrl_t;

    // second alu operand: rs2, immediate or constant four
    typedef logic [1:0] src2_sel_t;

    // immediate format, one bit per format
    typedef logic [4:0] ext_op_t;

endpackage

//--- tests/decode_stage_tb.sv
`timescale 1ns/1ns

module decode_stage_tb;

    import rv_decode_pkg::*;

    localparam string TRACE_FILE   = "tests/decode_trace.txt";
    localparam int    RESET_CYCLES = 5;
    localparam int    TRACE_FIELDS = 21;

    logic      clk;
    logic      arst_n_i;
    xlen_t     pc_i;
    instr_t    instr_i;
    xlen_t     wb_data_i;
    reg_idx_t  wb_rd_i;
    logic      wb_wren_i;
    logic      stall_o;
    xlen_t     pc_ex_o;
    xlen_t     rs1_data_ex_o;
    xlen_t     rs2_data_ex_o;
    xlen_t     imm_ex_o;
    logic      src1_sel_ex_o;
    src2_sel_t src2_sel_ex_o;
    alu_ctrl_t alu_ctrl_ex_o;
    reg_idx_t  rd_ex_o;
    logic      is_jal_ex_o;
    logic      is_jalr_ex_o;
    logic      is_brc_ex_o;
    logic      is_load_ex_o;
    logic      is_store_ex_o;
    logic      wben_ex_o;

    // fields of the current trace line
    int        line_test;
    instr_t    line_instr;
    xlen_t     line_pc;
    logic      line_wren;
    reg_idx_t  line_wrd;
    xlen_t     line_wdata;
    logic      exp_stall;
    logic      exp_full;
    logic      exp_wben;
    reg_idx_t  exp_rd;
    alu_ctrl_t exp_alu;
    logic      exp_src1;
    src2_sel_t exp_src2;
    xlen_t     exp_imm;
    xlen_t     exp_rs1;
    xlen_t     exp_rs2;
    logic      exp_jal;
    logic      exp_jalr;
    logic      exp_brc;
    logic      exp_load;
    logic      exp_store;

    // pc of the instruction now sitting in EX
    xlen_t     prev_pc;
    int        cur_test;
    int        test_errors;
    int        test_cycles;
    int        tests_done;
    int        tests_failed;
    int        error_count;
    int        cycle_count = 0;
    int        cycle_limit = 0;

    decode_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: trace not finished after %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic int count_trace_lines();
        int    fd;
        int    tnum;
        int    lines;
        string text;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            return -1;
        end
        lines = 0;
        while (!$feof(fd)) begin
            text = "";
            if ($fgets(text, fd) > 0 && $sscanf(text, "%d", tnum) == 1) begin
                lines++;
            end
        end
        $fclose(fd);
        return lines;
    endfunction

    task automatic value_error(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        $display("Fail at %0t ns: test %0d, %s is %h, expected %h",
                 $time, cur_test, what, got, want);
        test_errors++;
        error_count++;
    endtask

    task automatic finish_test();
        tests_done++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d finished: %0d cycles, %0d errors", cur_test, test_cycles,
                 test_errors);
    endtask

    // controls are checked always and data only when the slot is not a bubble
    task automatic check_ex_outputs();
        if (wben_ex_o !== exp_wben) value_error("wben", 64'(wben_ex_o), 64'(exp_wben));
        if (rd_ex_o !== exp_rd) value_error("rd", 64'(rd_ex_o), 64'(exp_rd));
        if (is_jal_ex_o !== exp_jal) value_error("is_jal", 64'(is_jal_ex_o), 64'(exp_jal));
        if (is_jalr_ex_o !== exp_jalr) value_error("is_jalr", 64'(is_jalr_ex_o), 64'(exp_jalr));
        if (is_brc_ex_o !== exp_brc) value_error("is_brc", 64'(is_brc_ex_o), 64'(exp_brc));
        if (is_load_ex_o !== exp_load) value_error("is_load", 64'(is_load_ex_o), 64'(exp_load));
        if (is_store_ex_o !== exp_store) value_error("is_store", 64'(is_store_ex_o),
                                                     64'(exp_store));
        if (exp_full) begin
            if (pc_ex_o !== prev_pc) value_error("pc", pc_ex_o, prev_pc);
            if (alu_ctrl_ex_o !== exp_alu) value_error("alu_ctrl", 64'(alu_ctrl_ex_o),
                                                       64'(exp_alu));
            if (src1_sel_ex_o !== exp_src1) value_error("src1_sel", 64'(src1_sel_ex_o),
                                                        64'(exp_src1));
            if (src2_sel_ex_o !== exp_src2) value_error("src2_sel", 64'(src2_sel_ex_o),
                                                        64'(exp_src2));
            if (imm_ex_o !== exp_imm) value_error("imm", imm_ex_o, exp_imm);
            if (rs1_data_ex_o !== exp_rs1) value_error("rs1_data", rs1_data_ex_o, exp_rs1);
            if (rs2_data_ex_o !== exp_rs2) value_error("rs2_data", rs2_data_ex_o, exp_rs2);
        end
    endtask

    // called on a falling edge while EX still holds the previous line
    task automatic run_trace_line();
        if (line_test != cur_test) begin
            if (cur_test != 0) begin
                finish_test();
            end
            cur_test    = line_test;
            test_errors = 0;
            test_cycles = 0;
        end
        check_ex_outputs();
        pc_i      = line_pc;
        instr_i   = line_instr;
        wb_rd_i   = line_wrd;
        wb_wren_i = line_wren;
        if (line_wren) begin
            wb_data_i = line_wdata;
        end else begin
            wb_data_i = {$urandom, $urandom};
        end
        #2;
        if (stall_o !== exp_stall) value_error("stall", 64'(stall_o), 64'(exp_stall));
        prev_pc = line_pc;
        test_cycles++;
    endtask

    initial begin
        int          fd;
        int          n;
        int          lines;
        string       text;
        arst_n_i     = 1'b0;
        pc_i         = '0;
        instr_i      = 32'h0000_0013;
        wb_data_i    = '0;
        wb_rd_i      = '0;
        wb_wren_i    = 1'b0;
        prev_pc      = '0;
        cur_test     = 0;
        test_errors  = 0;
        test_cycles  = 0;
        tests_done   = 0;
        tests_failed = 0;
        error_count  = 0;
        void'($urandom(32'h8ac));
        lines = count_trace_lines();
        if (lines <= 0) begin
            $display("trace file %s is missing or holds no lines", TRACE_FILE);
            $display("Simulation FAILED");
            $finish;
        end else begin
            cycle_limit = 3 * lines + RESET_CYCLES;
            fd = $fopen(TRACE_FILE, "r");
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            arst_n_i = 1'b1;
            while (!$feof(fd)) begin
                text = "";
                n = $fgets(text, fd);
                if (n > 0) begin
                    n = $sscanf(text,
                        "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        line_test, line_instr, line_pc, line_wren, line_wrd, line_wdata,
                        exp_stall, exp_full, exp_wben, exp_rd, exp_alu, exp_src1,
                        exp_src2, exp_imm, exp_rs1, exp_rs2, exp_jal, exp_jalr,
                        exp_brc, exp_load, exp_store);
                    if (n == TRACE_FIELDS) begin
                        run_trace_line();
                        @(negedge clk);
                    end else if (n > 0) begin
                        $display("trace line could not be read: %s", text);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
            if (cur_test != 0) begin
                finish_test();
            end
            $display("%0d tests run, %0d with errors, %0d errors in total", tests_done,
                     tests_failed, error_count);
            if (error_count == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

//--- tests/decode_trace.txt
# test instr pc wb_wren wb_rd wb_data stall full | ex: wben rd alu src1 src2 imm rs1 rs2
# jal jalr brc load store; ex columns belong to the previous line, full 0 marks a bubble
1 006280b3 00 0 00 0000 0 1 0 00 0 0 0 0 0 0 0 0 0 0 0
1 00000013 04 1 05 1111 0 1 1 01 0 0 0 0 0 0 0 0 0 0 0
2 00000013 08 1 06 2222 0 1 0 00 0 0 1 0 0 0 0 0 0 0 0
2 00000013 0c 1 00 dead 0 1 0 00 0 0 1 0 0 0 0 0 0 0 0
2 006283b3 10 0 00 0000 0 1 0 00 0 0 1 0 0 0 0 0 0 0 0
2 40500433 14 0 00 0000 0 1 1 07 0 0 0 0 1111 2222 0 0 0 0 0
2 006294b3 18 0 00 0000 0 1 1 08 2 0 0 0 0 1111 0 0 0 0 0
3 0062a4b3 1c 0 00 0000 0 1 1 09 4 0 0 0 1111 2222 0 0 0 0 0
3 0062b4b3 20 0 00 0000 0 1 1 09 a 0 0 0 1111 2222 0 0 0 0 0
3 0062c4b3 24 0 00 0000 0 1 1 09 b 0 0 0 1111 2222 0 0 0 0 0
3 0062d4b3 28 0 00 0000 0 1 1 09 c 0 0 0 1111 2222 0 0 0 0 0
3 4062d4b3 2c 0 00 0000 0 1 1 09 6 0 0 0 1111 2222 0 0 0 0 0
3 0062e4b3 30 0 00 0000 0 1 1 09 8 0 0 0 1111 2222 0 0 0 0 0
3 0062f4b3 34 0 00 0000 0 1 1 09 d 0 0 0 1111 2222 0 0 0 0 0
3 006284bb 38 0 00 0000 0 1 1 09 e 0 0 0 1111 2222 0 0 0 0 0
3 406284bb 3c 0 00 0000 0 1 1 09 1 0 0 0 1111 2222 0 0 0 0 0
3 4062d4bb 40 0 00 0000 0 1 1 09 3 0 0 0 1111 2222 0 0 0 0 0
3 fff28493 44 0 00 0000 0 1 1 09 9 0 0 0 1111 2222 0 0 0 0 0
3 4032d493 48 0 00 0000 0 1 1 09 0 0 1 ffffffffffffffff 1111 0 0 0 0 0 0
3 0052849b 4c 0 00 0000 0 1 1 09 8 0 1 403 1111 0 0 0 0 0 0
3 800004b7 50 0 00 0000 0 1 1 09 1 0 1 5 1111 0 0 0 0 0 0
4 12345497 54 0 00 0000 0 1 1 09 f 0 1 ffffffff80000000 0 0 0 0 0 0 0
4 ff1ff0ef 58 0 00 0000 0 1 1 09 0 1 1 12345000 0 0 0 0 0 0 0
4 7f0280e7 5c 0 00 0000 0 1 1 01 0 1 2 fffffffffffffff0 0 0 1 0 0 0 0
4 fe62bc23 60 0 00 0000 0 1 1 01 0 1 2 7f0 1111 0 0 1 0 0 0
4 00628863 64 0 00 0000 0 1 0 00 0 0 1 fffffffffffffff8 1111 2222 0 0 0 0 1
4 fe629ee3 68 0 00 0000 0 1 0 00 0 0 0 10 1111 2222 0 0 1 0 0
4 0082b503 6c 0 00 0000 0 1 0 00 0 0 0 fffffffffffffffc 1111 2222 0 0 1 0 0
5 006505b3 70 0 00 0000 1 1 1 0a 0 0 1 8 1111 0 0 0 0 1 0
5 006505b3 70 0 00 0000 0 0 0 00 0 0 0 0 0 0 0 0 0 0 0
5 0002b603 74 0 00 0000 0 1 1 0b 0 0 0 0 0 2222 0 0 0 0 0
5 005306b3 78 0 00 0000 0 1 1 0c 0 0 1 0 1111 0 0 0 0 1 0
5 0002b003 7c 0 00 0000 0 1 1 0d 0 0 0 0 2222 1111 0 0 0 0 0
5 006007b3 80 0 00 0000 0 1 0 00 0 0 1 0 1111 0 0 0 0 1 0
5 00000013 84 0 00 0000 0 1 1 0f 0 0 0 0 0 2222 0 0 0 0 0
